/* src/spim_pkg.sv */
`default_nettype none

package spim_pkg;

  ////////////////////////////////////////////////////////////
  // widths with a meaning
  ////////////////////////////////////////////////////////////

  // register byte address on the host bus
  typedef logic [15:0] reg_addr_t;
  // host bus data word
  typedef logic [31:0] reg_data_t;
  // one byte on the wire
  typedef logic [7:0]  spi_byte_t;
  // sclk half-period minus one, in aclk cycles
  typedef logic [3:0]  clk_div_t;

  // shift engine states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LEAD,
    ST_SHIFT,
    ST_TRAIL
  } shift_state_t;

  ////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////

  localparam reg_addr_t ADDR_CMD         = 16'h0000;
  localparam reg_addr_t ADDR_STATUS      = 16'h0004;
  localparam reg_addr_t ADDR_RX_DATA     = 16'h0020;
  localparam reg_addr_t ADDR_RBUF_STATUS = 16'h0048;
  localparam reg_addr_t ADDR_RBUF_CTRL   = 16'h004C;

  // unmapped address or read strobe low
  localparam reg_data_t READ_DEFAULT = 32'hdead_beef;

endpackage

`default_nettype wire

/* src/spim_reg.sv */
`default_nettype none

module spim_reg #(
  parameter int FIFO_ADDR_WIDTH = 2
) (
  input  logic                     aclk,
  input  logic                     arst_n,
  // host bus
  input  spim_pkg::reg_addr_t      addr,
  input  spim_pkg::reg_data_t      wdata,
  input  logic                     write,
  input  logic                     read,
  output spim_pkg::reg_data_t      rdata,
  // shift engine
  input  logic                     busy,
  input  logic                     done_pulse,
  output logic                     start_pulse,
  output spim_pkg::spi_byte_t      tx_byte,
  output spim_pkg::clk_div_t       clk_div,
  // receive buffer
  input  spim_pkg::spi_byte_t      head,
  input  logic [FIFO_ADDR_WIDTH:0] level,
  input  logic                     overflow_sticky,
  input  logic                     underflow_sticky,
  output logic                     pop,
  output logic                     soft_reset
);

  import spim_pkg::*;

  // command word, bit 0 start, 7:4 divider, 15:8 tx byte
  logic [15:0] cmd_q;
  reg_data_t   rbuf_status;
  reg_data_t   rbuf_ctrl;
  reg_data_t   status_word;
  logic        we_cmd;
  logic        we_rbuf_ctrl;

  ////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////

  assign we_cmd       = write && (addr == ADDR_CMD);
  assign we_rbuf_ctrl = write && (addr == ADDR_RBUF_CTRL);

  // reading the data port consumes the head entry
  assign pop = read && (addr == ADDR_RX_DATA);

  assign tx_byte    = cmd_q[15:8];
  assign clk_div    = cmd_q[7:4];
  assign soft_reset = rbuf_ctrl[0];

  // command register
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      cmd_q <= '0;
    end else if (we_cmd) begin
      // a fresh write wins over the end-of-transfer clear
      cmd_q <= wdata[15:0];
    end else if (done_pulse) begin
      cmd_q[0] <= 1'b0;
    end
  end

  // kick the engine only when it is idle
  // start written while busy just stays in cmd_q
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      start_pulse <= 1'b0;
    end else begin
      start_pulse <= we_cmd && wdata[0] && !busy;
    end
  end

  // buffer control, bit 0 soft reset held as a level
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      rbuf_ctrl <= '0;
    end else if (we_rbuf_ctrl) begin
      rbuf_ctrl <= wdata;
    end
  end

  // buffer status snapshot
  // level in bits 8 and up, overflow bit 1, underflow bit 0
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      rbuf_status <= '0;
    end else begin
      rbuf_status <= {{(23 - FIFO_ADDR_WIDTH){1'b0}}, level, 6'b0,
                      overflow_sticky, underflow_sticky};
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  // transfer counts as in flight from the kick until the push
  assign status_word = {30'b0, (level != '0), (start_pulse || busy || done_pulse)};

  always_comb begin
    rdata = READ_DEFAULT;
    if (read) begin
      case (addr)
        ADDR_CMD:         rdata = {16'b0, cmd_q};
        ADDR_STATUS:      rdata = status_word;
        ADDR_RX_DATA:     rdata = {24'b0, head};
        ADDR_RBUF_STATUS: rdata = rbuf_status;
        ADDR_RBUF_CTRL:   rdata = rbuf_ctrl;
        default:          rdata = READ_DEFAULT;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/spim_shift.sv */
`default_nettype none

module spim_shift (
  input  logic                aclk,
  input  logic                arst_n,
  input  logic                start_pulse,
  input  spim_pkg::spi_byte_t tx_byte,
  input  spim_pkg::clk_div_t  clk_div,
  output logic                busy,
  output logic                done_pulse,
  output spim_pkg::spi_byte_t rx_byte,
  output logic                sclk,
  output logic                mosi,
  output logic                cs_n,
  input  logic                miso
);

  import spim_pkg::*;

  shift_state_t state;
  clk_div_t     hp_cnt;
  clk_div_t     div_q;
  logic [2:0]   bit_cnt;
  spi_byte_t    tx_sr;
  spi_byte_t    rx_sr;
  logic         hp_end;

  // last cycle of the current half-period
  assign hp_end = (hp_cnt == div_q);

  assign busy    = (state != ST_IDLE);
  assign mosi    = tx_sr[7];
  assign rx_byte = rx_sr;

  ////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= ST_IDLE;
      hp_cnt     <= '0;
      bit_cnt    <= '0;
      sclk       <= 1'b0;
      cs_n       <= 1'b1;
      done_pulse <= 1'b0;
    end else begin
      done_pulse <= 1'b0;
      if (state != ST_IDLE) begin
        hp_cnt <= hp_end ? '0 : hp_cnt + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (start_pulse) begin
            state   <= ST_LEAD;
            hp_cnt  <= '0;
            bit_cnt <= '0;
            cs_n    <= 1'b0;
          end
        end
        // low half of bit 7, mosi already valid
        ST_LEAD: begin
          if (hp_end) begin
            sclk  <= 1'b1;
            state <= ST_SHIFT;
          end
        end
        ST_SHIFT: begin
          if (hp_end) begin
            sclk <= !sclk;
            // falling edge closes a bit
            if (sclk && (bit_cnt == 3'd7)) begin
              state <= ST_TRAIL;
            end else if (sclk) begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        // one low half-period before deselect
        ST_TRAIL: begin
          if (hp_end) begin
            state      <= ST_IDLE;
            cs_n       <= 1'b1;
            done_pulse <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if ((state == ST_IDLE) && start_pulse) begin
      // snapshot so later command writes do not disturb the transfer
      tx_sr <= tx_byte;
      div_q <= clk_div;
    end
    // sample miso on the edge that raises sclk
    if (hp_end && !sclk && ((state == ST_LEAD) || (state == ST_SHIFT))) begin
      rx_sr <= {rx_sr[6:0], miso};
    end
    // next bit out on falling sclk, msb first
    if (hp_end && sclk && (state == ST_SHIFT) && (bit_cnt != 3'd7)) begin
      tx_sr <= {tx_sr[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

/* src/spim_rx_fifo.sv */
`default_nettype none

module spim_rx_fifo #(
  parameter int FIFO_ADDR_WIDTH = 2
) (
  input  logic                     aclk,
  input  logic                     arst_n,
  input  logic                     push,
  input  spim_pkg::spi_byte_t      data_in,
  input  logic                     pop,
  input  logic                     soft_reset,
  output spim_pkg::spi_byte_t      head,
  output logic [FIFO_ADDR_WIDTH:0] level,
  output logic                     overflow_sticky,
  output logic                     underflow_sticky
);

  import spim_pkg::*;

  localparam int DEPTH = 1 << FIFO_ADDR_WIDTH;

  spi_byte_t                  mem [DEPTH];
  logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
  logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
  logic                       full;
  logic                       empty;
  logic                       do_push;
  logic                       do_pop;

  // level tops out at DEPTH so its msb alone marks full
  assign full  = level[FIFO_ADDR_WIDTH];
  assign empty = (level == '0);

  assign do_push = push && !full && !soft_reset;
  assign do_pop  = pop && !empty && !soft_reset;

  // empty reads give zero
  assign head = empty ? '0 : mem[rd_ptr];

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_in;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers, fill level, sticky flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr           <= '0;
      rd_ptr           <= '0;
      level            <= '0;
      overflow_sticky  <= 1'b0;
      underflow_sticky <= 1'b0;
    end else if (soft_reset) begin
      // host-driven flush, holds while the bit is set
      wr_ptr           <= '0;
      rd_ptr           <= '0;
      level            <= '0;
      overflow_sticky  <= 1'b0;
      underflow_sticky <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        level <= level + 1'b1;
      end else if (do_pop && !do_push) begin
        level <= level - 1'b1;
      end
      // dropped byte
      if (push && full) begin
        overflow_sticky <= 1'b1;
      end
      // read of nothing
      if (pop && empty) begin
        underflow_sticky <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/spim_top.sv */
`default_nettype none

module spim_top #(
  parameter int FIFO_ADDR_WIDTH = 2
) (
  input  logic                aclk,
  input  logic                arst_n,
  // host bus
  input  spim_pkg::reg_addr_t addr,
  input  spim_pkg::reg_data_t wdata,
  input  logic                write,
  input  logic                read,
  output spim_pkg::reg_data_t rdata,
  // spi pins
  output logic                sclk,
  output logic                mosi,
  input  logic                miso,
  output logic                cs_n
);

  // reg block to shift engine
  logic                       start_pulse;
  spim_pkg::spi_byte_t        tx_byte;
  spim_pkg::clk_div_t         clk_div;
  logic                       busy;
  logic                       done_pulse;
  spim_pkg::spi_byte_t        rx_byte;
  // reg block and receive buffer
  logic                       pop;
  logic                       soft_reset;
  spim_pkg::spi_byte_t        head;
  logic [FIFO_ADDR_WIDTH:0]   level;
  logic                       overflow_sticky;
  logic                       underflow_sticky;

  ////////////////////////////////////////////////////////////
  // decode, execute, result
  ////////////////////////////////////////////////////////////

  spim_reg #(
    .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) i_spim_reg (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .addr             (addr),
    .wdata            (wdata),
    .write            (write),
    .read             (read),
    .rdata            (rdata),
    .busy             (busy),
    .done_pulse       (done_pulse),
    .start_pulse      (start_pulse),
    .tx_byte          (tx_byte),
    .clk_div          (clk_div),
    .head             (head),
    .level            (level),
    .overflow_sticky  (overflow_sticky),
    .underflow_sticky (underflow_sticky),
    .pop              (pop),
    .soft_reset       (soft_reset)
  );

  spim_shift i_spim_shift (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .start_pulse (start_pulse),
    .tx_byte     (tx_byte),
    .clk_div     (clk_div),
    .busy        (busy),
    .done_pulse  (done_pulse),
    .rx_byte     (rx_byte),
    .sclk        (sclk),
    .mosi        (mosi),
    .cs_n        (cs_n),
    .miso        (miso)
  );

  // every finished transfer pushes its received byte
  spim_rx_fifo #(
    .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) i_spim_rx_fifo (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .push             (done_pulse),
    .data_in          (rx_byte),
    .pop              (pop),
    .soft_reset       (soft_reset),
    .head             (head),
    .level            (level),
    .overflow_sticky  (overflow_sticky),
    .underflow_sticky (underflow_sticky)
  );

endmodule

`default_nettype wire

/* dv/spim_checker.sv */
`default_nettype none

// watches the shift engine and receive buffer wires inside spim_top
module spim_checker #(
  parameter int FIFO_ADDR_WIDTH = 2
) (
  input  logic                     aclk,
  input  logic                     arst_n,
  input  logic                     busy,
  input  logic                     cs_n,
  input  logic                     done_pulse,
  input  logic [FIFO_ADDR_WIDTH:0] level
);

  // failed assertions, summed up by the testbench
  int fail_cnt = 0;

  // no slave selected outside a transfer
  cs_high_when_idle: assert property (@(posedge aclk) disable iff (!arst_n)
    !busy |-> cs_n)
    else begin
      $error("cs_n low while the shift engine is idle");
      fail_cnt++;
    end

  // end of transfer marker lasts exactly one cycle
  done_one_cycle: assert property (@(posedge aclk) disable iff (!arst_n)
    done_pulse |=> !done_pulse)
    else begin
      $error("done_pulse held for more than one cycle");
      fail_cnt++;
    end

  // fill level bounded by buffer depth
  level_in_range: assert property (@(posedge aclk) disable iff (!arst_n)
    int'(level) <= (1 << FIFO_ADDR_WIDTH))
    else begin
      $error("receive buffer level above its depth");
      fail_cnt++;
    end

endmodule

bind spim_top spim_checker #(
  .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
) i_spim_checker (
  .aclk       (aclk),
  .arst_n     (arst_n),
  .busy       (busy),
  .cs_n       (cs_n),
  .done_pulse (done_pulse),
  .level      (level)
);

`default_nettype wire

/* dv/spim_monitor.sv */
`default_nettype none

module spim_monitor (
  input  logic                aclk,
  input  logic                arst_n,
  // bus side
  input  logic                read,
  input  spim_pkg::reg_data_t rdata,
  input  logic                chk_read,
  input  spim_pkg::reg_data_t exp_rdata,
  // spi side
  input  logic                sclk,
  input  logic                mosi,
  input  logic                cs_n,
  input  spim_pkg::spi_byte_t exp_tx,
  input  spim_pkg::clk_div_t  exp_div,
  // running totals
  output int                  errors,
  output int                  checks
);

  import spim_pkg::*;

  logic      sclk_q;
  logic      cs_n_q;
  spi_byte_t mosi_bits;
  int        rises;
  int        run_len;
  int        low_cycles;

  // one sclk half-period against div+1 aclk cycles
  task automatic check_half(input int len);
    checks++;
    if (len != int'(exp_div) + 1) begin
      errors++;
      $display("Error at %0t: sclk half-period of %0d cycles, expected %0d",
               $time, len, int'(exp_div) + 1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // sampling on aclk, values from before the edge
  ////////////////////////////////////////////////////////////

  always @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      errors     = 0;
      checks     = 0;
      sclk_q     = 1'b0;
      cs_n_q     = 1'b1;
      mosi_bits  = '0;
      rises      = 0;
      run_len    = 0;
      low_cycles = 0;
    end else begin
      // only reads the tb flagged carry an expectation
      if (read && chk_read) begin
        checks++;
        if (rdata !== exp_rdata) begin
          errors++;
          $display("Error at %0t: read returned %h, expected %h", $time, rdata, exp_rdata);
        end
      end
      if (!cs_n && cs_n_q) begin
        // first cycle of a transfer
        low_cycles = 1;
        run_len    = 1;
        rises      = 0;
        mosi_bits  = '0;
      end else if (!cs_n) begin
        low_cycles++;
        if (sclk == sclk_q) begin
          run_len++;
        end else begin
          check_half(run_len);
          run_len = 1;
          // rising sclk, mosi holds the current bit
          if (sclk) begin
            mosi_bits = {mosi_bits[6:0], mosi};
            rises++;
          end
        end
      end else if (!cs_n_q) begin
        // deselect, close the trail half and the whole frame
        check_half(run_len);
        checks += 3;
        if (rises != 8) begin
          errors++;
          $display("Error at %0t: %0d sclk rises, expected 8", $time, rises);
        end
        if (mosi_bits != exp_tx) begin
          errors++;
          $display("Error at %0t: mosi byte %h, expected %h", $time, mosi_bits, exp_tx);
        end
        if (low_cycles != 17 * (int'(exp_div) + 1)) begin
          errors++;
          $display("Error at %0t: cs_n low for %0d cycles, expected %0d",
                   $time, low_cycles, 17 * (int'(exp_div) + 1));
        end
      end
      sclk_q = sclk;
      cs_n_q = cs_n;
    end
  end

endmodule

`default_nettype wire

/* dv/spim_tb.sv */
`default_nettype none

module spim_tb;

  import spim_pkg::*;

  logic      aclk;
  logic      arst_n;
  reg_addr_t addr;
  reg_data_t wdata;
  logic      write;
  logic      read;
  reg_data_t rdata;
  logic      sclk;
  logic      mosi;
  logic      miso;
  logic      cs_n;
  // expectations handed to the monitor
  spi_byte_t exp_tx;
  clk_div_t  exp_div;
  reg_data_t exp_rdata;
  logic      chk_read;
  int        mon_errors;
  int        mon_checks;
  // slave model
  spi_byte_t slave_byte;
  spi_byte_t miso_sr;
  logic      sclk_prev;
  int        tb_errors;

  spim_top i_spim_top (
    .aclk   (aclk),
    .arst_n (arst_n),
    .addr   (addr),
    .wdata  (wdata),
    .write  (write),
    .read   (read),
    .rdata  (rdata),
    .sclk   (sclk),
    .mosi   (mosi),
    .miso   (miso),
    .cs_n   (cs_n)
  );

  spim_monitor i_spim_monitor (
    .aclk      (aclk),
    .arst_n    (arst_n),
    .read      (read),
    .rdata     (rdata),
    .chk_read  (chk_read),
    .exp_rdata (exp_rdata),
    .sclk      (sclk),
    .mosi      (mosi),
    .cs_n      (cs_n),
    .exp_tx    (exp_tx),
    .exp_div   (exp_div),
    .errors    (mon_errors),
    .checks    (mon_checks)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  // mode 0 slave model
  // msb ready at select and next bit after each falling sclk
  always @(posedge aclk) begin
    #5;
    if (cs_n) begin
      miso_sr = slave_byte;
    end else if (sclk_prev && !sclk) begin
      miso_sr = {miso_sr[6:0], 1'b0};
    end
    sclk_prev = sclk;
    miso      = miso_sr[7];
  end

  ////////////////////////////////////////////////////////////
  // bus driver tasks start and end 5 after an edge
  ////////////////////////////////////////////////////////////

  task automatic bus_write(input reg_addr_t a, input reg_data_t d);
    addr  = a;
    wdata = d;
    write = 1'b1;
    @(posedge aclk);
    #5;
    write = 1'b0;
  endtask

  // monitor compares rdata at the edge
  task automatic bus_read_check(input reg_addr_t a, input reg_data_t e);
    addr      = a;
    exp_rdata = e;
    read      = 1'b1;
    chk_read  = 1'b1;
    @(posedge aclk);
    #5;
    read     = 1'b0;
    chk_read = 1'b0;
  endtask

  // status bit 0 low once the byte sits in the buffer
  task automatic wait_transfer_done();
    int   n;
    logic in_flight;
    n         = 0;
    in_flight = 1'b1;
    while (in_flight && n < 2000) begin
      addr = ADDR_STATUS;
      read = 1'b1;
      #40;
      in_flight = rdata[0];
      @(posedge aclk);
      #5;
      read = 1'b0;
      n++;
    end
    if (in_flight) begin
      tb_errors++;
      $display("timeout: transfer still busy after 2000 cycles at time %0t", $time);
    end
  endtask

  task automatic idle_gap();
    int gap;
    gap = 1 + int'($urandom % 3);
    repeat (gap) begin
      @(posedge aclk);
      #5;
    end
  endtask

  function automatic int total_errors();
    return mon_errors + tb_errors + i_spim_top.i_spim_checker.fail_cnt;
  endfunction

  ////////////////////////////////////////////////////////////
  // trace reader
  ////////////////////////////////////////////////////////////

  initial begin
    int                fd;
    int                code;
    int                test_num;
    int                errs_before;
    logic              more;
    logic [7:0]        op;
    logic [31:0]       f1;
    logic [31:0]       f2;
    logic [31:0]       f3;
    logic [8*128-1:0]  junk;
    addr       = '0;
    wdata      = '0;
    write      = 1'b0;
    read       = 1'b0;
    miso       = 1'b0;
    arst_n     = 1'b0;
    exp_tx     = '0;
    exp_div    = '0;
    exp_rdata  = '0;
    chk_read   = 1'b0;
    slave_byte = '0;
    miso_sr    = '0;
    sclk_prev  = 1'b0;
    tb_errors  = 0;
    test_num   = 0;
    void'($urandom(32'hd324));
    repeat (10) @(posedge aclk);
    #5;
    arst_n      = 1'b1;
    errs_before = 0;
    fd = $fopen("dv/spim_trace.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("could not open the trace file dv/spim_trace.txt");
    end
    more = (fd != 0);
    while (more) begin
      code = $fscanf(fd, " %c", op);
      if (code != 1) begin
        more = 1'b0;
      end else begin
        case (op)
          "#": code = $fgets(junk, fd);
          "W": begin
            code = $fscanf(fd, "%h %h", f1, f2);
            bus_write(f1[15:0], f2);
            idle_gap();
          end
          "R": begin
            code = $fscanf(fd, "%h %h", f1, f2);
            bus_read_check(f1[15:0], f2);
            idle_gap();
          end
          "X": begin
            code       = $fscanf(fd, "%h %h %h", f1, f2, f3);
            slave_byte = f2[7:0];
            exp_tx     = f1[7:0];
            exp_div    = f3[3:0];
            // start in bit 0 with divider in 7:4 and tx byte in 15:8
            bus_write(ADDR_CMD, {16'h0, f1[7:0], f3[3:0], 4'h1});
            wait_transfer_done();
            idle_gap();
          end
          "E": begin
            test_num++;
            $display("test %0d finished, %0d errors", test_num, total_errors() - errs_before);
            errs_before = total_errors();
          end
          default: begin
            tb_errors++;
            $display("unknown trace operation '%c'", op);
          end
        endcase
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (test_num == 0) begin
      tb_errors++;
      $display("no test found in the trace file");
    end
    $display("summary: %0d tests, %0d bus and spi checks, %0d errors",
             test_num, mon_checks, total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/spim_trace.txt */
# W addr data | R addr expected | X tx miso div | E ends a test
# all fields hex, # starts a comment line
R 0000 00000000
R 0004 00000000
R 0048 00000000
R 0010 deadbeef
E
X a5 3c 1
R 0020 0000003c
R 0000 0000a510
E
X 5a 81 0
X c3 7e 1
X 0f f0 3
R 0020 00000081
R 0020 0000007e
R 0020 000000f0
E
X 11 01 0
X 22 02 0
X 33 03 0
X 44 04 0
X 55 05 0
R 0048 00000402
R 0020 00000001
R 0020 00000002
R 0020 00000003
R 0020 00000004
R 0020 00000000
R 0048 00000003
E
W 004c 00000001
W 004c 00000000
R 0048 00000000
X 96 69 2
R 0048 00000100
R 0020 00000069
E

/* filelist.f */
src/spim_pkg.sv
src/spim_reg.sv
src/spim_shift.sv
src/spim_rx_fifo.sv
src/spim_top.sv
dv/spim_checker.sv
dv/spim_monitor.sv
dv/spim_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module spim_tb -f filelist.f -o spim_sim \
  && ./obj_dir/spim_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
